// ==== rtl/g729_pitch_settings.svh ====
`ifndef G729_PITCH_SETTINGS_SVH
`define G729_PITCH_SETTINGS_SVH

// excitation memory word address
`define EXC_ADDR_W 12

// interpolation filter shape
`define INTER_TAPS 10  // taps on each side
`define UP_SAMP 3      // upsampling factor
`define INTER_LEN 31   // UP_SAMP * INTER_TAPS + 1
`define INTER_IDX_W 5

// longest sub-frame handled
`define SUBFR_MAX 40

`endif

// ==== rtl/g729_pitch_pkg.sv ====
`include "g729_pitch_settings.svh"

package g729_pitch_pkg;

	// Q15 speech sample, also used for table coefficients
	typedef logic signed [15:0] sample_t;

	// L_mac accumulator
	typedef logic signed [31:0] acc_t;

	// word address into the excitation RAM
	typedef logic [`EXC_ADDR_W-1:0] exc_addr_t;

endpackage

// ==== rtl/basic_op_unit.sv ====
`include "g729_pitch_settings.svh"

module basic_op_unit (
	input  g729_pitch_pkg::sample_t add_a,
	input  g729_pitch_pkg::sample_t add_b,
	output g729_pitch_pkg::sample_t add_out,
	input  g729_pitch_pkg::sample_t sub_a,
	input  g729_pitch_pkg::sample_t sub_b,
	output g729_pitch_pkg::sample_t sub_out,
	input  g729_pitch_pkg::sample_t neg_in,
	output g729_pitch_pkg::sample_t neg_out,
	input  g729_pitch_pkg::acc_t    mac_acc,
	input  g729_pitch_pkg::sample_t mac_a,
	input  g729_pitch_pkg::sample_t mac_b,
	output g729_pitch_pkg::acc_t    mac_out,
	input  g729_pitch_pkg::acc_t    round_in,
	output g729_pitch_pkg::sample_t round_out
);
	import g729_pitch_pkg::*;

	acc_t prod;
	acc_t mult;
	acc_t round_sum;

	// clip a 17-bit sum into 16 bits
	function automatic sample_t sat16(input logic signed [16:0] v);
		if (v > 17'sd32767)
			return 16'sh7fff;
		else if (v < -17'sd32768)
			return 16'sh8000;
		return v[15:0];
	endfunction

	// L_add, 32-bit add with saturation
	function automatic acc_t l_add(input acc_t a, input acc_t b);
		logic signed [32:0] sum;
		sum = {a[31], a} + {b[31], b};
		if (sum[32] != sum[31])
			return sum[32] ? 32'sh8000_0000 : 32'sh7fff_ffff;
		return sum[31:0];
	endfunction

	assign add_out = sat16({add_a[15], add_a} + {add_b[15], add_b});
	assign sub_out = sat16({sub_a[15], sub_a} - {sub_b[15], sub_b});
	assign neg_out = (neg_in == 16'sh8000) ? 16'sh7fff : -neg_in;

	////////////////////////////////////////
	// L_mult then L_add
	////////////////////////////////////////
	assign prod = mac_a * mac_b;
	assign mult = (prod == 32'sh4000_0000) ? 32'sh7fff_ffff : (prod <<< 1); // -1 * -1 clips
	assign mac_out = l_add(mac_acc, mult);

	assign round_sum = l_add(round_in, 32'sh0000_8000);
	assign round_out = round_sum[31:16]; // upper half after rounding

endmodule

// ==== rtl/inter_3l_rom.sv ====
`include "g729_pitch_settings.svh"

module inter_3l_rom (
	input  logic                    clk,
	input  logic [`INTER_IDX_W-1:0] addr,
	output g729_pitch_pkg::sample_t data
);
	import g729_pitch_pkg::*;

	sample_t coef;

	// 1/3 resolution interpolation filter in Q15
	always_comb
	begin
		case (addr)
			5'd0:    coef = 16'sd29443;
			5'd1:    coef = 16'sd25207;
			5'd2:    coef = 16'sd14701;
			5'd3:    coef = 16'sd3143;
			5'd4:    coef = -16'sd4402;
			5'd5:    coef = -16'sd5850;
			5'd6:    coef = -16'sd2783;
			5'd7:    coef = 16'sd1211;
			5'd8:    coef = 16'sd3130;
			5'd9:    coef = 16'sd2259;
			5'd11:   coef = -16'sd1652;
			5'd12:   coef = -16'sd1666;
			5'd13:   coef = -16'sd464;
			5'd14:   coef = 16'sd756;
			5'd15:   coef = 16'sd1099;
			5'd16:   coef = 16'sd550;
			5'd17:   coef = -16'sd245;
			5'd18:   coef = -16'sd634;
			5'd19:   coef = -16'sd451;
			5'd21:   coef = 16'sd308;
			5'd22:   coef = 16'sd296;
			5'd23:   coef = 16'sd78;
			5'd24:   coef = -16'sd120;
			5'd25:   coef = -16'sd165;
			5'd26:   coef = -16'sd79;
			5'd27:   coef = 16'sd34;
			5'd28:   coef = 16'sd91;
			5'd29:   coef = 16'sd70;
			default: coef = 16'sd0; // zero crossings at 10, 20, 30 and past the end
		endcase
	end

	always_ff @(posedge clk)
	begin
		data <= coef;
	end

endmodule

// ==== rtl/excitation_ram.sv ====
`include "g729_pitch_settings.svh"

module excitation_ram (
	input  logic                      clk,
	input  logic                      en,
	input  logic                      we,
	input  g729_pitch_pkg::exc_addr_t addr,
	input  g729_pitch_pkg::sample_t   wdata,
	output g729_pitch_pkg::sample_t   rdata
);
	import g729_pitch_pkg::*;

	localparam int DEPTH = 1 << `EXC_ADDR_W;

	sample_t mem [DEPTH];

	// one port, read data lands the next cycle
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (we)
				mem[addr] <= wdata;
			else
				rdata <= mem[addr];
		end
	end

endmodule

// ==== rtl/exc_mem_arbiter.sv ====
`include "g729_pitch_settings.svh"

module exc_mem_arbiter (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      lt_busy,
	input  logic                      lt_req_valid,
	input  logic                      lt_req_write,
	output logic                      lt_req_ready,
	input  g729_pitch_pkg::exc_addr_t lt_req_addr,
	input  g729_pitch_pkg::sample_t   lt_req_wdata,
	output logic                      lt_rsp_valid,
	output g729_pitch_pkg::sample_t   lt_rsp_data,
	input  logic                      host_req_valid,
	input  logic                      host_req_write,
	output logic                      host_req_ready,
	input  g729_pitch_pkg::exc_addr_t host_req_addr,
	input  g729_pitch_pkg::sample_t   host_req_wdata,
	output logic                      host_rsp_valid,
	output g729_pitch_pkg::sample_t   host_rsp_data,
	output logic                      ram_en,
	output logic                      ram_we,
	output g729_pitch_pkg::exc_addr_t ram_addr,
	output g729_pitch_pkg::sample_t   ram_wdata,
	input  g729_pitch_pkg::sample_t   ram_rdata
);

	logic lt_fire;
	logic host_fire;
	logic rd_lt;   // read in flight for the interpolator
	logic rd_host; // read in flight for the host

	////////////////////////////////////////
	// grant
	////////////////////////////////////////
	assign lt_req_ready = 1'b1; // interpolator always wins
	assign host_req_ready = !lt_busy && !lt_req_valid;

	assign lt_fire = lt_req_valid && lt_req_ready;
	assign host_fire = host_req_valid && host_req_ready;

	assign ram_en = lt_fire || host_fire;
	assign ram_we = lt_fire ? lt_req_write : (host_fire && host_req_write);
	assign ram_addr = lt_fire ? lt_req_addr : host_req_addr;
	assign ram_wdata = lt_fire ? lt_req_wdata : host_req_wdata;

	// remember who owns the read coming back
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_lt <= 1'b0;
			rd_host <= 1'b0;
		end
		else
		begin
			rd_lt <= lt_fire && !lt_req_write;
			rd_host <= host_fire && !host_req_write;
		end
	end

	assign lt_rsp_valid = rd_lt;
	assign lt_rsp_data = ram_rdata;
	assign host_rsp_valid = rd_host;
	assign host_rsp_data = ram_rdata;

endmodule

// ==== rtl/pred_lt_3.sv ====
`include "g729_pitch_settings.svh"

module pred_lt_3 (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  g729_pitch_pkg::exc_addr_t exc_base,
	input  g729_pitch_pkg::sample_t   t0,
	input  g729_pitch_pkg::sample_t   frac,
	input  g729_pitch_pkg::sample_t   l_subfr,
	output logic                      busy,
	output logic                      done,
	output logic                      req_valid,
	output logic                      req_write,
	input  logic                      req_ready,
	output g729_pitch_pkg::exc_addr_t req_addr,
	output g729_pitch_pkg::sample_t   req_wdata,
	input  logic                      rsp_valid,
	input  g729_pitch_pkg::sample_t   rsp_data,
	output logic [`INTER_IDX_W-1:0]   rom_addr,
	input  g729_pitch_pkg::sample_t   rom_data
);
	import g729_pitch_pkg::*;

	localparam int LEN_W = $clog2(`SUBFR_MAX + 1);
	localparam int TAP_W = $clog2(`INTER_TAPS);
	localparam int IDX_W = `INTER_IDX_W;

	localparam logic [2:0] S_IDLE   = 3'd0;
	localparam logic [2:0] S_NEG    = 3'd1;
	localparam logic [2:0] S_SAMPLE = 3'd2;
	localparam logic [2:0] S_COEF   = 3'd3;
	localparam logic [2:0] S_TAP_A  = 3'd4;
	localparam logic [2:0] S_TAP_B  = 3'd5;
	localparam logic [2:0] S_WRITE  = 3'd6;

	logic [2:0] state;
	logic [LEN_W-1:0] j;
	logic [LEN_W-1:0] len_r;
	logic [TAP_W-1:0] i;
	logic [IDX_W-1:0] k;    // 3*i
	logic [IDX_W-1:0] c1;
	logic [IDX_W-1:0] c2;
	logic fire;
	exc_addr_t base_r;
	exc_addr_t x0;
	exc_addr_t x1;
	exc_addr_t x2;
	sample_t frac_r;
	acc_t s;

	sample_t add_out;
	sample_t sub_out;
	sample_t neg_out;
	acc_t mac_out;
	sample_t round_out;

	basic_op_unit u_ops (
		.add_a(neg_out),
		.add_b(sample_t'(`UP_SAMP)),
		.add_out(add_out),
		.sub_a(sample_t'(`UP_SAMP)),
		.sub_b(frac_r),
		.sub_out(sub_out),
		.neg_in(frac_r),
		.neg_out(neg_out),
		.mac_acc(s),
		.mac_a(rsp_data),
		.mac_b(rom_data),
		.mac_out(mac_out),
		.round_in(rsp_valid ? mac_out : s), // last tap folds into the round
		.round_out(round_out)
	);

	assign fire = req_valid && req_ready;
	assign busy = (state != S_IDLE);
	assign c1 = frac_r[IDX_W-1:0];

	////////////////////////////////////////
	// memory and table requests
	////////////////////////////////////////
	always_comb
	begin
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = x1 - exc_addr_t'(i); // x1[-i]
		req_wdata = round_out;
		rom_addr = c1 + k;
		case (state)
			S_TAP_A:
				req_valid = 1'b1;
			S_TAP_B:
			begin
				req_valid = 1'b1;
				req_addr = x2 + exc_addr_t'(i); // x2[i]
				rom_addr = c2 + k;
			end
			S_WRITE:
			begin
				req_valid = 1'b1;
				req_write = 1'b1;
				req_addr = base_r + exc_addr_t'(j); // exc[j]
			end
			default: ;
		endcase
	end

	////////////////////////////////////////
	// loop control
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= S_IDLE;
			i <= '0;
			j <= '0;
			k <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
				S_IDLE:
					if (start)
					begin
						j <= '0;
						state <= S_NEG;
					end
				S_NEG:
					if (len_r == '0)
					begin
						done <= 1'b1; // nothing to build
						state <= S_IDLE;
					end
					else
						state <= S_SAMPLE;
				S_SAMPLE:
				begin
					i <= '0;
					k <= '0;
					state <= S_COEF;
				end
				S_COEF:
					state <= S_TAP_A;
				S_TAP_A:
					if (fire)
						state <= S_TAP_B;
				S_TAP_B:
					if (fire)
					begin
						if (i == TAP_W'(`INTER_TAPS - 1))
							state <= S_WRITE;
						else
						begin
							i <= i + 1'b1;
							k <= k + IDX_W'(`UP_SAMP);
							state <= S_TAP_A;
						end
					end
				S_WRITE:
					if (fire)
					begin
						j <= j + 1'b1;
						if (j + 1'b1 == len_r)
						begin
							done <= 1'b1;
							state <= S_IDLE;
						end
						else
							state <= S_SAMPLE;
					end
				default:
					state <= S_IDLE;
			endcase
		end
	end

	////////////////////////////////////////
	// pointers, fraction and accumulator
	////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		case (state)
			S_IDLE:
				if (start)
				begin
					base_r <= exc_base;
					x0 <= exc_base - exc_addr_t'(t0); // &exc[-t0]
					frac_r <= frac;
					if (l_subfr > sample_t'(`SUBFR_MAX))
						len_r <= LEN_W'(`SUBFR_MAX);
					else if (l_subfr < 0)
						len_r <= '0;
					else
						len_r <= l_subfr[LEN_W-1:0];
				end
			S_NEG:
				if (neg_out < 0)
				begin
					frac_r <= add_out; // frac += 3
					x0 <= x0 - 1'b1;
				end
				else
					frac_r <= neg_out;
			S_SAMPLE:
			begin
				x1 <= x0;
				x2 <= x0 + 1'b1;
				x0 <= x0 + 1'b1;
			end
			default: ;
		endcase

		if (state == S_COEF)
		begin
			c2 <= sub_out[IDX_W-1:0]; // 3 - frac
			s <= '0;
		end
		else if (rsp_valid)
			s <= mac_out;
	end

endmodule

// ==== rtl/pitch_interp_top.sv ====
`include "g729_pitch_settings.svh"

module pitch_interp_top (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      start,
	input  g729_pitch_pkg::exc_addr_t exc_base,
	input  g729_pitch_pkg::sample_t   t0,
	input  g729_pitch_pkg::sample_t   frac,
	input  g729_pitch_pkg::sample_t   l_subfr,
	output logic                      busy,
	output logic                      done,
	input  logic                      host_req_valid,
	input  logic                      host_req_write,
	output logic                      host_req_ready,
	input  g729_pitch_pkg::exc_addr_t host_req_addr,
	input  g729_pitch_pkg::sample_t   host_req_wdata,
	output logic                      host_rsp_valid,
	output g729_pitch_pkg::sample_t   host_rsp_data
);
	import g729_pitch_pkg::*;

	// interpolator side of the arbiter
	logic lt_req_valid;
	logic lt_req_write;
	logic lt_req_ready;
	exc_addr_t lt_req_addr;
	sample_t lt_req_wdata;
	logic lt_rsp_valid;
	sample_t lt_rsp_data;

	// RAM port
	logic ram_en;
	logic ram_we;
	exc_addr_t ram_addr;
	sample_t ram_wdata;
	sample_t ram_rdata;

	logic [`INTER_IDX_W-1:0] rom_addr;
	sample_t rom_data;

	pred_lt_3 u_pred (
		.clk(clk),
		.reset(reset),
		.start(start),
		.exc_base(exc_base),
		.t0(t0),
		.frac(frac),
		.l_subfr(l_subfr),
		.busy(busy),
		.done(done),
		.req_valid(lt_req_valid),
		.req_write(lt_req_write),
		.req_ready(lt_req_ready),
		.req_addr(lt_req_addr),
		.req_wdata(lt_req_wdata),
		.rsp_valid(lt_rsp_valid),
		.rsp_data(lt_rsp_data),
		.rom_addr(rom_addr),
		.rom_data(rom_data)
	);

	exc_mem_arbiter u_arb (
		.clk(clk),
		.reset(reset),
		.lt_busy(busy),
		.lt_req_valid(lt_req_valid),
		.lt_req_write(lt_req_write),
		.lt_req_ready(lt_req_ready),
		.lt_req_addr(lt_req_addr),
		.lt_req_wdata(lt_req_wdata),
		.lt_rsp_valid(lt_rsp_valid),
		.lt_rsp_data(lt_rsp_data),
		.host_req_valid(host_req_valid),
		.host_req_write(host_req_write),
		.host_req_ready(host_req_ready),
		.host_req_addr(host_req_addr),
		.host_req_wdata(host_req_wdata),
		.host_rsp_valid(host_rsp_valid),
		.host_rsp_data(host_rsp_data),
		.ram_en(ram_en),
		.ram_we(ram_we),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata),
		.ram_rdata(ram_rdata)
	);

	excitation_ram u_ram (
		.clk(clk),
		.en(ram_en),
		.we(ram_we),
		.addr(ram_addr),
		.wdata(ram_wdata),
		.rdata(ram_rdata)
	);

	inter_3l_rom u_rom (
		.clk(clk),
		.addr(rom_addr),
		.data(rom_data)
	);

endmodule

// ==== tests/pitch_interp_model.sv ====
module pitch_interp_model;
	timeunit 1ns;
	timeprecision 1ps;
	import g729_pitch_pkg::*;

	localparam int DEPTH = 4096;
	localparam longint MAX32 = 64'sh7fff_ffff;
	localparam longint MIN32 = -64'sh8000_0000;

	// G.729 inter_3l, 1/3 resolution, Q15
	localparam int INTER_3L [31] = '{
		29443, 25207, 14701, 3143, -4402, -5850, -2783, 1211, 3130, 2259,
		0, -1652, -1666, -464, 756, 1099, 550, -245, -634, -451,
		0, 308, 296, 78, -120, -165, -79, 34, 91, 70, 0
	};

	sample_t mem [DEPTH]; // mirror of the excitation RAM

	task automatic store(input int addr, input sample_t v);
		mem[addr & (DEPTH - 1)] = v;
	endtask

	function automatic sample_t fetch(input int addr);
		return mem[addr & (DEPTH - 1)];
	endfunction

	function automatic longint sat32(input longint v);
		if (v > MAX32)
			return MAX32;
		if (v < MIN32)
			return MIN32;
		return v;
	endfunction

	// doubled product, clipped, then added with clipping
	function automatic longint mac(input longint s, input sample_t a, input int c);
		longint p;
		p = 2 * longint'(a) * longint'(c);
		if (p > MAX32)
			p = MAX32;
		return sat32(s + p);
	endfunction

	function automatic sample_t round16(input longint s);
		longint r;
		r = sat32(s + 64'sd32768);
		return sample_t'(r >>> 16);
	endfunction

	////////////////////////////////////////
	// adaptive codebook prediction, in place
	////////////////////////////////////////
	task automatic predict(input int base, input int lag, input int fr, input int len);
		int x0;
		int x1;
		int x2;
		int f;
		longint s;
		f = -fr;
		x0 = base - lag;
		if (f < 0)
		begin
			f = f + 3;
			x0 = x0 - 1; // one sample further back
		end
		for (int j = 0; j < len; j++)
		begin
			x1 = x0;
			x0 = x0 + 1;
			x2 = x0;
			s = 0;
			for (int i = 0; i < 10; i++)
			begin
				s = mac(s, fetch(x1 - i), INTER_3L[f + 3 * i]);
				s = mac(s, fetch(x2 + i), INTER_3L[3 - f + 3 * i]);
			end
			store(base + j, round16(s)); // later taps may read this back
		end
	endtask

endmodule

// ==== tests/pitch_interp_tb.sv ====
module pitch_interp_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import g729_pitch_pkg::*;

	localparam logic [31:0] LFSR_SEED = 32'hbf9f;
	localparam int NUM_TESTS = 20;
	localparam int RAM_WORDS = 4096;
	localparam int CYCLE_LIMIT = NUM_TESTS * (4096 + 40 * 45 + 40) + 20000;
	localparam int DRIVE_DELAY = 5;

	logic clk;
	logic reset;
	logic start;
	exc_addr_t exc_base;
	sample_t t0;
	sample_t frac;
	sample_t l_subfr;
	logic busy;
	logic done;
	logic host_req_valid;
	logic host_req_write;
	logic host_req_ready;
	exc_addr_t host_req_addr;
	sample_t host_req_wdata;
	logic host_rsp_valid;
	sample_t host_rsp_data;

	logic [31:0] lfsr;
	int cycles;
	int done_count;

	pitch_interp_top uut (
		.clk(clk),
		.reset(reset),
		.start(start),
		.exc_base(exc_base),
		.t0(t0),
		.frac(frac),
		.l_subfr(l_subfr),
		.busy(busy),
		.done(done),
		.host_req_valid(host_req_valid),
		.host_req_write(host_req_write),
		.host_req_ready(host_req_ready),
		.host_req_addr(host_req_addr),
		.host_req_wdata(host_req_wdata),
		.host_rsp_valid(host_rsp_valid),
		.host_rsp_data(host_rsp_data)
	);

	pitch_interp_model model ();

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Test failed");
		$fatal(1);
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			stop_run("Timeout: the run did not finish within its cycle limit");
	end

	// done pulses and host stall while the interpolator runs
	always @(negedge clk)
	begin
		if (done)
			done_count++;
		if (busy)
			assert (!host_req_ready)
			else stop_run("host request was granted while the interpolator was busy");
	end

	// fibonacci LFSR with taps x^32 + x^22 + x^2 + x + 1
	function automatic int unsigned take_bits(input int n);
		int unsigned v;
		logic fb;
		v = 0;
		repeat (n)
		begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	////////////////////////////////////////
	// host port
	////////////////////////////////////////
	task automatic host_access(input logic wr, input int addr, input sample_t wdata,
		output sample_t rdata);
		rdata = '0;
		host_req_valid = 1'b1;
		host_req_write = wr;
		host_req_addr = exc_addr_t'(addr);
		host_req_wdata = wdata;
		@(negedge clk);
		assert (!host_rsp_valid) else stop_run("host response arrived with no read pending");
		while (!host_req_ready)
		begin
			assert (busy) else stop_run("host request stalled with the interpolator idle");
			@(negedge clk);
		end
		next_cycle(); // transfer on this edge
		host_req_valid = 1'b0;
		if (!wr)
		begin
			@(negedge clk);
			assert (host_rsp_valid)
			else stop_run("host read response was not valid one cycle after the request");
			rdata = host_rsp_data;
			next_cycle();
		end
	endtask

	task automatic load_history(input int mode);
		int a;
		sample_t v;
		sample_t unused;
		for (a = 0; a < RAM_WORDS; a++)
		begin
			case (mode)
				1: v = 16'sh7fff;
				2: v = 16'sh8000;
				default: v = sample_t'(take_bits(16));
			endcase
			model.store(a, v);
			host_access(1'b1, a, v, unused);
		end
	endtask

	task automatic spot_check(input int count);
		int a;
		sample_t got;
		repeat (count)
		begin
			a = int'(take_bits(12));
			host_access(1'b0, a, 16'sd0, got);
			assert (got == model.fetch(a))
			else stop_run($sformatf("Mismatch at %0t: ram[%0d] read %0d, wrote %0d",
				$time, a, got, model.fetch(a)));
		end
	endtask

	////////////////////////////////////////
	// one interpolation run and readback
	////////////////////////////////////////
	task automatic run_and_check(input int base, input int lag, input int fr, input int len,
		input int mode);
		int dones_before;
		int j;
		sample_t got;
		dones_before = done_count;
		model.predict(base, lag, fr, len);
		start = 1'b1;
		exc_base = exc_addr_t'(base);
		t0 = sample_t'(lag);
		frac = sample_t'(fr);
		l_subfr = sample_t'(len);
		next_cycle();
		start = 1'b0;
		assert (busy) else stop_run("busy did not rise after start");
		// issued mid-run and held off until done
		host_access(1'b0, base + len, 16'sd0, got);
		assert (done_count == dones_before + 1) else stop_run("start did not give one done pulse");
		assert (got == model.fetch(base + len))
		else stop_run($sformatf("Mismatch at %0t: word after the sub-frame is %0d, loaded %0d",
			$time, got, model.fetch(base + len)));
		for (j = 0; j < len; j++)
		begin
			host_access(1'b0, base + j, 16'sd0, got);
			if (mode == 1)
			begin
				assert (got > 0)
				else stop_run($sformatf(
					"Mismatch at %0t: exc[%0d] is %0d, positive history wrapped",
					$time, j, got));
			end
			else if (mode == 2)
			begin
				assert (got < 0)
				else stop_run($sformatf(
					"Mismatch at %0t: exc[%0d] is %0d, negative history wrapped",
					$time, j, got));
			end
			assert (got == model.fetch(base + j))
			else stop_run($sformatf(
				"Mismatch at %0t: exc[%0d] is %0d, expected %0d (t0 %0d frac %0d)",
				$time, j, got, model.fetch(base + j), lag, fr));
		end
		host_access(1'b0, base - 1, 16'sd0, got);
		assert (got == model.fetch(base - 1))
		else stop_run($sformatf("Mismatch at %0t: word before the sub-frame is %0d, loaded %0d",
			$time, got, model.fetch(base - 1)));
		assert (done_count == dones_before + 1) else stop_run("extra done pulse after the run");
	endtask

	initial
	begin
		int t;
		int mode;
		lfsr = LFSR_SEED;
		done_count = 0;
		reset = 1'b1;
		start = 1'b0;
		exc_base = '0;
		t0 = '0;
		frac = '0;
		l_subfr = '0;
		host_req_valid = 1'b0;
		host_req_write = 1'b0;
		host_req_addr = '0;
		host_req_wdata = '0;
		repeat (8) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		@(negedge clk);
		assert (!busy && !done && !host_rsp_valid) else stop_run("outputs not idle after reset");
		next_cycle();

		for (t = 0; t < NUM_TESTS; t++)
		begin
			mode = (t % 5 == 1) ? 1 : ((t % 5 == 3) ? 2 : 0); // full-scale fills
			load_history(mode);
			spot_check(4);
			repeat (take_bits(3)) next_cycle(); // idle gap
			run_and_check(int'(take_bits(12)), 20 + int'(take_bits(7) % 121),
				int'(take_bits(2) % 3) - 1, 1 + int'(take_bits(6) % 40), mode);
		end

		$display("Test passed");
		$finish;
	end

endmodule

// ==== g729_pitch.f ====
+incdir+rtl
rtl/g729_pitch_pkg.sv
rtl/basic_op_unit.sv
rtl/inter_3l_rom.sv
rtl/excitation_ram.sv
rtl/exc_mem_arbiter.sv
rtl/pred_lt_3.sv
rtl/pitch_interp_top.sv
tests/pitch_interp_model.sv
tests/pitch_interp_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the pitch interpolation testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f g729_pitch.f --top-module pitch_interp_tb -o sim_pitch > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "build failed"
	exit 1
fi

./obj_dir/sim_pitch > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
exit 0
